//--- compile.f
+incdir+design
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/cpu_alu.sv
design/cpu_decoder.sv
design/cpu_sequencer.sv
design/cpu_execute.sv
design/cpu_6502_core.sv
bench/tb_cpu_6502_core.sv

//--- bench/tb_cpu_6502_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu_6502_core import cpu_isa_pkg::*; ();

    localparam int          N_INSTR    = 400;
    localparam int          MAX_CYCLES = N_INSTR * 3 * 2 + 100;
    localparam logic [15:0] PROG_BASE  = 16'h0200;

    logic        i_clk;
    logic        i_reset_n;
    logic        i_rdy;
    logic [7:0]  i_bus_data;
    logic [2:0]  i_debug_sel;
    logic [15:0] o_bus_addr;
    logic        o_sync;
    logic [7:0]  o_debug_data;

    logic [7:0]  mem [0:65535];
    logic [15:0] prog_addr [0:N_INSTR];
    logic [7:0]  prog_op [0:N_INSTR];
    logic [31:0] rng;

    // instruction-level model state
    logic [7:0]  m_a, m_x, m_y;
    logic        m_n, m_v, m_i, m_z, m_c;
    logic [15:0] m_pc;
    logic [15:0] end_addr;

    int          errors, checks, cycles, ready_count, rot, final_idx;
    logic        last_rdy, prev_sync, started, done, timed_out;
    logic [15:0] prev_addr;

    cpu_6502_core dut0 (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_rdy        (i_rdy),
        .i_bus_data   (i_bus_data),
        .i_debug_sel  (i_debug_sel),
        .o_bus_addr   (o_bus_addr),
        .o_sync       (o_sync),
        .o_debug_data (o_debug_data)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic int instr_len(input logic [7:0] op);
        case (op)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM, OP_SBC_IMM,
            OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM, OP_CMP_IMM: return 2;
            OP_JMP_ABS: return 3;
            default: return 1;
        endcase
    endfunction

    // kept opcodes other than jmp
    function automatic logic is_kept(input logic [7:0] op);
        case (op)
            OP_INX, OP_INY, OP_DEX, OP_DEY, OP_TAX, OP_TAY, OP_TXA, OP_TYA,
            OP_CLC, OP_SEC, OP_CLV, OP_NOP: return 1'b1;
            default: return instr_len(op) == 2;
        endcase
    endfunction

    function automatic logic [7:0] expected_debug(input logic [2:0] sel, input logic [15:0] pc);
        case (sel)
            3'd0:    return m_a;
            3'd1:    return m_x;
            3'd2:    return m_y;
            3'd3:    return {m_n, m_v, 2'b11, 1'b0, m_i, m_z, m_c};
            3'd4:    return pc[15:8];
            3'd5:    return pc[7:0];
            default: return 8'h00;
        endcase
    endfunction

    task automatic build_program;
        int          i;
        int          a;
        int          target;
        logic [15:0] addr;
        logic [7:0]  op;
        for (a = 0; a < 65536; a++)
            mem[a] = 8'(draw_random());
        mem[`CPU_RESET_VECTOR]         = PROG_BASE[7:0];
        mem[`CPU_RESET_VECTOR + 16'd1] = PROG_BASE[15:8];
        addr = PROG_BASE;
        for (i = 0; i < N_INSTR; i++) begin
            if (draw_random() % 20 == 0) begin
                op = OP_JMP_ABS;
            end else begin
                op = 8'(draw_random());
                while (!is_kept(op))
                    op = 8'(draw_random());
            end
            prog_op[i]   = op;
            prog_addr[i] = addr;
            addr         = addr + 16'(instr_len(op));
        end
        // program ends in a jump to itself
        prog_op[N_INSTR]   = OP_JMP_ABS;
        prog_addr[N_INSTR] = addr;
        end_addr           = addr;
        for (i = 0; i <= N_INSTR; i++) begin
            mem[prog_addr[i]] = prog_op[i];
            if (prog_op[i] == OP_JMP_ABS) begin
                target = i + 1 + int'(draw_random() % 6);
                if (target > N_INSTR)
                    target = N_INSTR;
                mem[prog_addr[i] + 16'd1] = prog_addr[target][7:0];
                mem[prog_addr[i] + 16'd2] = prog_addr[target][15:8];
            end else if (instr_len(prog_op[i]) == 2) begin
                mem[prog_addr[i] + 16'd1] = 8'(draw_random());
            end
        end
    endtask

    task automatic set_nz(input logic [7:0] v);
        m_n = v[7];
        m_z = (v == 8'd0);
    endtask

    task automatic add_with_carry(input logic [7:0] rhs);
        logic [8:0] sum;
        sum = {1'b0, m_a} + {1'b0, rhs} + {8'd0, m_c};
        m_v = ((m_a ^ sum[7:0]) & (rhs ^ sum[7:0]) & 8'h80) != 8'd0;
        m_c = sum[8];
        m_a = sum[7:0];
    endtask

    task automatic step_model;
        logic [7:0] op;
        logic [7:0] arg;
        op  = mem[m_pc];
        arg = mem[m_pc + 16'd1];
        case (op)
            OP_LDA_IMM: m_a = arg;
            OP_LDX_IMM: m_x = arg;
            OP_LDY_IMM: m_y = arg;
            OP_ADC_IMM: add_with_carry(arg);
            OP_SBC_IMM: add_with_carry(~arg);
            OP_AND_IMM: m_a = m_a & arg;
            OP_ORA_IMM: m_a = m_a | arg;
            OP_EOR_IMM: m_a = m_a ^ arg;
            OP_CMP_IMM: m_c = (m_a >= arg);
            OP_INX:     m_x = m_x + 8'd1;
            OP_INY:     m_y = m_y + 8'd1;
            OP_DEX:     m_x = m_x - 8'd1;
            OP_DEY:     m_y = m_y - 8'd1;
            OP_TAX:     m_x = m_a;
            OP_TAY:     m_y = m_a;
            OP_TXA:     m_a = m_x;
            OP_TYA:     m_a = m_y;
            OP_CLC:     m_c = 1'b0;
            OP_SEC:     m_c = 1'b1;
            OP_CLV:     m_v = 1'b0;
            default: ;
        endcase
        // n and z follow the written register
        case (op)
            OP_LDX_IMM, OP_INX, OP_DEX, OP_TAX: set_nz(m_x);
            OP_LDY_IMM, OP_INY, OP_DEY, OP_TAY: set_nz(m_y);
            OP_CMP_IMM: set_nz(m_a - arg);
            OP_LDA_IMM, OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM,
            OP_EOR_IMM, OP_TXA, OP_TYA: set_nz(m_a);
            default: ;
        endcase
        if (op == OP_JMP_ABS)
            m_pc = {mem[m_pc + 16'd2], arg};
        else
            m_pc = m_pc + 16'(instr_len(op));
    endtask

    task automatic check_startup;
        logic [15:0] exp_addr;
        logic        exp_sync;
        exp_sync = (ready_count >= `CPU_INIT_CYCLES + 2);
        if (ready_count < `CPU_INIT_CYCLES)
            exp_addr = 16'h0000;
        else if (ready_count == `CPU_INIT_CYCLES)
            exp_addr = `CPU_RESET_VECTOR;
        else if (ready_count == `CPU_INIT_CYCLES + 1)
            exp_addr = `CPU_RESET_VECTOR + 16'd1;
        else
            exp_addr = m_pc;
        checks++;
        if (o_sync !== exp_sync || o_bus_addr !== exp_addr) begin
            errors++;
            $display("Error at %0t: start-up step %0d, addr %h sync %b, expected %h %b",
                     $time, ready_count, o_bus_addr, o_sync, exp_addr, exp_sync);
        end
        if (o_sync)
            started = 1'b1;
    endtask

    task automatic run_cycle;
        logic [2:0] sel;
        logic       rdy_now;
        rdy_now = (draw_random() % 8) != 0;
        // bus holds still across a stall
        if (!last_rdy) begin
            checks++;
            if (o_bus_addr !== prev_addr || o_sync !== prev_sync) begin
                errors++;
                $display("Error at %0t: stall changed addr %h -> %h, sync %b -> %b",
                         $time, prev_addr, o_bus_addr, prev_sync, o_sync);
            end
        end
        i_rdy      = rdy_now;
        i_bus_data = mem[o_bus_addr];
        if (!started) begin
            if (last_rdy)
                ready_count++;
            check_startup;
        end
        if (started && o_sync) begin
            checks++;
            if (o_bus_addr !== m_pc) begin
                errors++;
                $display("Error at %0t: fetch at %h, model pc %h", $time, o_bus_addr, m_pc);
            end
            if (m_pc == end_addr)
                sel = 3'(final_idx);
            else
                sel = 3'(rot % 6);
            i_debug_sel = sel;
            #1;
            checks++;
            if (o_debug_data !== expected_debug(sel, m_pc)) begin
                errors++;
                $display("Error at %0t: debug sel %0d read %h, expected %h at pc %h", $time,
                         sel, o_debug_data, expected_debug(sel, m_pc), m_pc);
            end
            if (m_pc == end_addr) begin
                final_idx++;
                done = (final_idx == 4);
            end else if (rdy_now) begin
                step_model;
                rot++;
            end
        end
        last_rdy  = rdy_now;
        prev_addr = o_bus_addr;
        prev_sync = o_sync;
    endtask

    initial begin
        i_reset_n   = 1'b0;
        i_rdy       = 1'b1;
        i_bus_data  = 8'h00;
        i_debug_sel = 3'd0;
        rng         = 32'd68059;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        ready_count = 0;
        rot         = 0;
        final_idx   = 0;
        started     = 1'b0;
        done        = 1'b0;
        timed_out   = 1'b0;
        build_program();
        m_a  = 8'd0;
        m_x  = 8'd0;
        m_y  = 8'd0;
        // status 0x34 once the reset wait is over
        {m_n, m_v, m_i, m_z, m_c} = 5'b00100;
        m_pc = {mem[`CPU_RESET_VECTOR + 16'd1], mem[`CPU_RESET_VECTOR]};
        repeat (4) @(negedge i_clk);
        i_reset_n = 1'b1;
        last_rdy  = 1'b1;
        prev_addr = o_bus_addr;
        prev_sync = o_sync;
        while (!done && !timed_out) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: end of program not reached within %0d cycles", MAX_CYCLES);
                timed_out = 1'b1;
            end else begin
                run_cycle();
            end
        end
        $display("%0d errors in %0d checks, %0d instructions, %0d cycles",
                 errors, checks, rot, cycles);
        if (errors == 0 && !timed_out)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/cpu_6502_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_6502_core import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset_n,
    input  wire logic        i_rdy,
    input  wire logic [7:0]  i_bus_data,
    input  wire logic [2:0]  i_debug_sel,
    output logic      [15:0] o_bus_addr,
    output logic             o_sync,
    output logic      [7:0]  o_debug_data
);

    logic [7:0]  opcode;
    logic [7:0]  operand;
    logic [15:0] pc;
    logic        commit;
    logic        init_done;
    logic [1:0]  length;
    alu_op_t     alu_op;
    dest_t       dest;
    dest_t       src_sel;
    flag_upd_t   flag_upd;
    logic        use_operand;

    cpu_sequencer seq0 (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_rdy       (i_rdy),
        .i_bus_data  (i_bus_data),
        .i_length    (length),
        .o_bus_addr  (o_bus_addr),
        .o_sync      (o_sync),
        .o_opcode    (opcode),
        .o_operand   (operand),
        .o_pc        (pc),
        .o_commit    (commit),
        .o_init_done (init_done)
    );

    cpu_decoder dec0 (
        .i_opcode      (opcode),
        .o_alu_op      (alu_op),
        .o_dest        (dest),
        .o_flag_upd    (flag_upd),
        .o_src_sel     (src_sel),
        .o_use_operand (use_operand),
        .o_length      (length)
    );

    cpu_execute exe0 (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_commit      (commit),
        .i_init_done   (init_done),
        .i_opcode      (opcode),
        .i_operand     (operand),
        .i_pc          (pc),
        .i_alu_op      (alu_op),
        .i_dest        (dest),
        .i_flag_upd    (flag_upd),
        .i_src_sel     (src_sel),
        .i_use_operand (use_operand),
        .i_debug_sel   (i_debug_sel),
        .o_debug_data  (o_debug_data)
    );

endmodule

`default_nettype wire

//--- design/cpu_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_execute import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset_n,
    input  wire logic        i_commit,
    input  wire logic        i_init_done,
    input  wire logic [7:0]  i_opcode,
    input  wire logic [7:0]  i_operand,
    input  wire logic [15:0] i_pc,
    input  alu_op_t          i_alu_op,
    input  dest_t            i_dest,
    input  flag_upd_t        i_flag_upd,
    input  dest_t            i_src_sel,
    input  wire logic        i_use_operand,
    input  wire logic [2:0]  i_debug_sel,
    output logic      [7:0]  o_debug_data
);

    localparam logic [7:0] status_reset = `CPU_P_RESET;

    logic [7:0] reg_a, reg_x, reg_y;
    logic       flag_n, flag_v, flag_i, flag_z, flag_c;
    logic [7:0] alu_lhs, alu_rhs;
    logic       alu_carry_in;
    logic [7:0] alu_result;
    logic       alu_carry, alu_overflow;
    logic [7:0] status;

    always_comb begin
        case (i_src_sel)
            DEST_A:  alu_lhs = reg_a;
            DEST_X:  alu_lhs = reg_x;
            DEST_Y:  alu_lhs = reg_y;
            default: alu_lhs = i_operand;
        endcase
        // inc/dec add 1 or -1
        if (i_use_operand)
            alu_rhs = i_operand;
        else if (i_opcode == OP_DEX || i_opcode == OP_DEY)
            alu_rhs = 8'hFF;
        else
            alu_rhs = 8'h01;
        // cmp forces carry, adc/sbc use the flag
        if (i_dest == DEST_FLAGS_ONLY)
            alu_carry_in = 1'b1;
        else
            alu_carry_in = i_use_operand & flag_c;
    end

    cpu_alu alu0 (
        .i_op       (i_alu_op),
        .i_lhs      (alu_lhs),
        .i_rhs      (alu_rhs),
        .i_carry    (alu_carry_in),
        .o_result   (alu_result),
        .o_carry    (alu_carry),
        .o_overflow (alu_overflow)
    );

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            reg_a <= 8'd0;
            reg_x <= 8'd0;
            reg_y <= 8'd0;
        end else if (i_commit) begin
            case (i_dest)
                DEST_A:  reg_a <= alu_result;
                DEST_X:  reg_x <= alu_result;
                DEST_Y:  reg_y <= alu_result;
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            {flag_n, flag_v, flag_i, flag_z, flag_c} <= 5'd0;
        end else if (i_init_done) begin
            flag_n <= status_reset[`CPU_FLAG_N];
            flag_v <= status_reset[`CPU_FLAG_V];
            flag_i <= status_reset[`CPU_FLAG_I];
            flag_z <= status_reset[`CPU_FLAG_Z];
            flag_c <= status_reset[`CPU_FLAG_C];
        end else if (i_commit) begin
            if (i_flag_upd == UPD_NZ || i_flag_upd == UPD_NZC || i_flag_upd == UPD_NVZC) begin
                flag_n <= alu_result[7];
                flag_z <= (alu_result == 8'd0);
            end
            if (i_flag_upd == UPD_NZC || i_flag_upd == UPD_NVZC)
                flag_c <= alu_carry;
            if (i_flag_upd == UPD_NVZC)
                flag_v <= alu_overflow;
            if (i_flag_upd == SET_C || i_flag_upd == CLR_C)
                flag_c <= (i_flag_upd == SET_C);
            if (i_flag_upd == CLR_V)
                flag_v <= 1'b0;
        end
    end

    always_comb begin
        status = 8'h30;
        status[`CPU_FLAG_N] = flag_n;
        status[`CPU_FLAG_V] = flag_v;
        status[`CPU_FLAG_I] = flag_i;
        status[`CPU_FLAG_Z] = flag_z;
        status[`CPU_FLAG_C] = flag_c;
    end

    always_comb begin
        case (i_debug_sel)
            3'd0:    o_debug_data = reg_a;
            3'd1:    o_debug_data = reg_x;
            3'd2:    o_debug_data = reg_y;
            3'd3:    o_debug_data = status;
            3'd4:    o_debug_data = i_pc[15:8];
            3'd5:    o_debug_data = i_pc[7:0];
            3'd6:    o_debug_data = i_opcode;
            default: o_debug_data = 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_sequencer import cpu_ctrl_pkg::*, cpu_isa_pkg::*; (
    input  wire logic        i_clk,
    input  wire logic        i_reset_n,
    input  wire logic        i_rdy,
    input  wire logic [7:0]  i_bus_data,
    input  wire logic [1:0]  i_length,
    output logic      [15:0] o_bus_addr,
    output logic             o_sync,
    output logic      [7:0]  o_opcode,
    output logic      [7:0]  o_operand,
    output logic      [15:0] o_pc,
    output logic             o_commit,
    output logic             o_init_done
);

    seq_state_t  state;
    logic [2:0]  init_count;
    logic        init_last;
    logic [7:0]  operand_q;
    logic [15:0] pc_next;
    logic [15:0] jump_target;

    assign init_last   = (init_count == 3'(`CPU_INIT_CYCLES - 1));
    assign pc_next     = o_pc + {14'd0, i_length};
    assign jump_target = {i_bus_data, operand_q};

    assign o_sync      = (state == ST_FETCH);
    assign o_operand   = (state == ST_OPERAND) ? i_bus_data : operand_q;
    assign o_init_done = i_rdy && (state == ST_INIT) && init_last;
    assign o_commit    = i_rdy && (state == ST_ADDR_HI ||
                         (state == ST_OPERAND && o_opcode != OP_JMP_ABS));

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            state      <= ST_INIT;
            init_count <= 3'd0;
            o_pc       <= 16'd0;
            o_bus_addr <= 16'd0;
            o_opcode   <= 8'd0;
        end else if (i_rdy) begin
            case (state)
                ST_INIT: begin
                    if (init_last) begin
                        o_bus_addr <= `CPU_RESET_VECTOR;
                        state      <= ST_VEC_LO;
                    end else begin
                        init_count <= init_count + 3'd1;
                    end
                end
                ST_VEC_LO: begin
                    o_pc[7:0]  <= i_bus_data;
                    o_bus_addr <= `CPU_RESET_VECTOR + 16'd1;
                    state      <= ST_VEC_HI;
                end
                ST_VEC_HI: begin
                    o_pc       <= {i_bus_data, o_pc[7:0]};
                    o_bus_addr <= {i_bus_data, o_pc[7:0]};
                    state      <= ST_FETCH;
                end
                ST_FETCH: begin
                    o_opcode   <= i_bus_data;
                    o_bus_addr <= o_pc + 16'd1;
                    state      <= ST_OPERAND;
                end
                ST_OPERAND: begin
                    // jmp reads a second address byte
                    if (o_opcode == OP_JMP_ABS) begin
                        o_bus_addr <= o_pc + 16'd2;
                        state      <= ST_ADDR_HI;
                    end else begin
                        o_pc       <= pc_next;
                        o_bus_addr <= pc_next;
                        state      <= ST_FETCH;
                    end
                end
                ST_ADDR_HI: begin
                    o_pc       <= jump_target;
                    o_bus_addr <= jump_target;
                    state      <= ST_FETCH;
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rdy && state == ST_OPERAND)
            operand_q <= i_bus_data;
    end

endmodule

`default_nettype wire

//--- design/cpu_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_decoder import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
    input  wire logic [7:0] i_opcode,
    output alu_op_t         o_alu_op,
    output dest_t           o_dest,
    output flag_upd_t       o_flag_upd,
    output dest_t           o_src_sel,
    output logic            o_use_operand,
    output logic [1:0]      o_length
);

    opcode_t op;

    assign op = opcode_t'(i_opcode);

    always_comb begin
        o_alu_op      = ALU_PASS;
        o_dest        = DEST_NONE;
        o_flag_upd    = UPD_NONE;
        o_src_sel     = DEST_NONE;
        o_use_operand = 1'b0;
        o_length      = 2'd1;
        case (op)
            // loads pass the operand straight through
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
                o_use_operand = 1'b1;
                o_length      = 2'd2;
                o_flag_upd    = UPD_NZ;
                if (op == OP_LDA_IMM)
                    o_dest = DEST_A;
                else if (op == OP_LDX_IMM)
                    o_dest = DEST_X;
                else
                    o_dest = DEST_Y;
            end
            OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM, OP_CMP_IMM: begin
                o_src_sel     = DEST_A;
                o_use_operand = 1'b1;
                o_length      = 2'd2;
                o_dest        = DEST_A;
                o_flag_upd    = UPD_NZ;
                case (op)
                    OP_ADC_IMM: o_alu_op = ALU_ADD;
                    OP_SBC_IMM: o_alu_op = ALU_SUB;
                    OP_AND_IMM: o_alu_op = ALU_AND;
                    OP_ORA_IMM: o_alu_op = ALU_ORA;
                    OP_EOR_IMM: o_alu_op = ALU_EOR;
                    default:    o_alu_op = ALU_SUB;
                endcase
                if (op == OP_ADC_IMM || op == OP_SBC_IMM)
                    o_flag_upd = UPD_NVZC;
                // compare only touches the flags
                if (op == OP_CMP_IMM) begin
                    o_dest     = DEST_FLAGS_ONLY;
                    o_flag_upd = UPD_NZC;
                end
            end
            OP_INX, OP_DEX, OP_INY, OP_DEY: begin
                o_alu_op   = ALU_ADD;
                o_flag_upd = UPD_NZ;
                o_dest     = (op == OP_INX || op == OP_DEX) ? DEST_X : DEST_Y;
                o_src_sel  = o_dest;
            end
            OP_TAX: begin
                o_src_sel  = DEST_A;
                o_dest     = DEST_X;
                o_flag_upd = UPD_NZ;
            end
            OP_TAY: begin
                o_src_sel  = DEST_A;
                o_dest     = DEST_Y;
                o_flag_upd = UPD_NZ;
            end
            OP_TXA: begin
                o_src_sel  = DEST_X;
                o_dest     = DEST_A;
                o_flag_upd = UPD_NZ;
            end
            OP_TYA: begin
                o_src_sel  = DEST_Y;
                o_dest     = DEST_A;
                o_flag_upd = UPD_NZ;
            end
            OP_CLC: o_flag_upd = CLR_C;
            OP_SEC: o_flag_upd = SET_C;
            OP_CLV: o_flag_upd = CLR_V;
            OP_JMP_ABS: o_length = 2'd3;
            // NOP and unknown opcodes keep the defaults
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_alu import cpu_isa_pkg::*; (
    input  alu_op_t          i_op,
    input  wire logic [7:0]  i_lhs,
    input  wire logic [7:0]  i_rhs,
    input  wire logic        i_carry,
    output logic      [7:0]  o_result,
    output logic             o_carry,
    output logic             o_overflow
);

    logic [7:0] rhs_eff;
    logic [8:0] sum;

    // subtract is add of the complement
    assign rhs_eff = (i_op == ALU_SUB) ? ~i_rhs : i_rhs;
    assign sum     = {1'b0, i_lhs} + {1'b0, rhs_eff} + {8'd0, i_carry};

    // carry and overflow only mean something for add and sub
    assign o_carry    = sum[8];
    assign o_overflow = (i_lhs[7] == rhs_eff[7]) && (sum[7] != i_lhs[7]);

    always_comb begin
        case (i_op)
            ALU_ADD,
            ALU_SUB:  o_result = sum[7:0];
            ALU_AND:  o_result = i_lhs & i_rhs;
            ALU_ORA:  o_result = i_lhs | i_rhs;
            ALU_EOR:  o_result = i_lhs ^ i_rhs;
            ALU_PASS: o_result = i_lhs;
            default:  o_result = i_lhs;
        endcase
    end

endmodule

`default_nettype wire

//--- design/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_INIT, ST_VEC_LO, ST_VEC_HI, ST_FETCH, ST_OPERAND, ST_ADDR_HI
    } seq_state_t;

    // also used as the source select, where DEST_NONE means the operand
    typedef enum logic [2:0] {
        DEST_NONE, DEST_A, DEST_X, DEST_Y, DEST_FLAGS_ONLY
    } dest_t;

    typedef enum logic [2:0] {
        UPD_NONE, UPD_NZ, UPD_NZC, UPD_NVZC, SET_C, CLR_C, CLR_V
    } flag_upd_t;

endpackage

`default_nettype wire

//--- design/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // kept opcodes at their standard encodings
    typedef enum logic [7:0] {
        OP_LDA_IMM = 8'hA9,
        OP_LDX_IMM = 8'hA2,
        OP_LDY_IMM = 8'hA0,
        OP_ADC_IMM = 8'h69,
        OP_SBC_IMM = 8'hE9,
        OP_AND_IMM = 8'h29,
        OP_ORA_IMM = 8'h09,
        OP_EOR_IMM = 8'h49,
        OP_CMP_IMM = 8'hC9,
        OP_INX     = 8'hE8,
        OP_INY     = 8'hC8,
        OP_DEX     = 8'hCA,
        OP_DEY     = 8'h88,
        OP_TAX     = 8'hAA,
        OP_TAY     = 8'hA8,
        OP_TXA     = 8'h8A,
        OP_TYA     = 8'h98,
        OP_CLC     = 8'h18,
        OP_SEC     = 8'h38,
        OP_CLV     = 8'hB8,
        OP_NOP     = 8'hEA,
        OP_JMP_ABS = 8'h4C
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_ORA,
        ALU_EOR,
        ALU_PASS
    } alu_op_t;

endpackage

`default_nettype wire

//--- design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// low byte of the reset vector
`define CPU_RESET_VECTOR 16'hFFFC
`define CPU_INIT_CYCLES 6

// status byte bit positions
`define CPU_FLAG_N 7
`define CPU_FLAG_V 6
`define CPU_FLAG_I 2
`define CPU_FLAG_Z 1
`define CPU_FLAG_C 0

`define CPU_P_RESET 8'h34

`endif
